//--- hdl/video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

//------------------
// horizontal raster, in pixel clocks
//------------------

// visible pixels per line
`define H_ACTIVE   640
// blank pixels between the last visible pixel and hsync
`define H_FRONT    16
// hsync pulse width
`define H_SYNC     96
// whole line including back porch
`define H_TOTAL    800

//------------------
// vertical raster, in lines
//------------------

`define V_ACTIVE   480
`define V_FRONT    10
`define V_SYNC     2
`define V_TOTAL    525

//------------------
// test picture
//------------------

// eight bars across the visible width
`define BAR_WIDTH  80

`endif

//--- hdl/video_pkg.sv
package video_pkg;

    //------------------
    // raster position
    //------------------

    // wide enough for both 0..799 and 0..524
    typedef logic [9:0] coord_t;

    //------------------
    // pixel data
    //------------------

    // one colour channel
    typedef logic [7:0] colour_t;

    // red in the top byte, blue in the bottom byte
    typedef struct packed
    {
        colour_t red;
        colour_t green;
        colour_t blue;
    } pixel_t;

    //------------------
    // DVI link
    //------------------

    // one encoded symbol, bit 0 goes out first on the wire
    typedef logic [9:0] tmds_word_t;

    // running ones minus zeros count of the sent data words
    typedef logic signed [4:0] disparity_t;

endpackage

//--- hdl/video_if.sv
// one pixel clock worth of raster state passed between pipeline stages
interface video_if;

    logic                hsync;
    logic                vsync;
    logic                de;
    video_pkg::coord_t   x;
    video_pkg::coord_t   y;
    video_pkg::pixel_t   pixel;

    // the stage that produces the raster
    modport src
    (
        output hsync,
        output vsync,
        output de,
        output x,
        output y,
        output pixel
    );

    // the stage that consumes it
    modport snk
    (
        input  hsync,
        input  vsync,
        input  de,
        input  x,
        input  y,
        input  pixel
    );

endinterface

//--- hdl/vga_timing.sv
`include "video_macros.svh"

module vga_timing
(
    input  logic  clk,
    input  logic  i_arst_n,
    video_if.src  raster
);

    //------------------
    // sync windows
    //------------------

    localparam video_pkg::coord_t h_last   = video_pkg::coord_t'(`H_TOTAL - 1);
    localparam video_pkg::coord_t v_last   = video_pkg::coord_t'(`V_TOTAL - 1);

    localparam video_pkg::coord_t hs_start = video_pkg::coord_t'(`H_ACTIVE + `H_FRONT);
    localparam video_pkg::coord_t hs_end   = video_pkg::coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);

    localparam video_pkg::coord_t vs_start = video_pkg::coord_t'(`V_ACTIVE + `V_FRONT);
    localparam video_pkg::coord_t vs_end   = video_pkg::coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    video_pkg::coord_t h_cnt;
    video_pkg::coord_t v_cnt;

    //------------------
    // position counters
    //------------------

    // pixel counter wraps every line, line counter every frame
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == h_last)
        begin
            h_cnt <= '0;

            if (v_cnt == v_last)
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    //------------------
    // raster outputs
    //------------------

    // position and its sync levels leave together from one register stage
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            raster.x     <= '0;
            raster.y     <= '0;
            raster.hsync <= 1'b0;
            raster.vsync <= 1'b0;
            raster.de    <= 1'b0;
        end
        else
        begin
            raster.x     <= h_cnt;
            raster.y     <= v_cnt;
            raster.hsync <= (h_cnt >= hs_start) && (h_cnt < hs_end);
            raster.vsync <= (v_cnt >= vs_start) && (v_cnt < vs_end);
            raster.de    <= (h_cnt < video_pkg::coord_t'(`H_ACTIVE))
                         && (v_cnt < video_pkg::coord_t'(`V_ACTIVE));
        end
    end

    // no colour is made here, bar_pattern paints it
    assign raster.pixel = '0;

    //------------------
    // checks
    //------------------

    a_x_in_line: assert property (@(posedge clk) disable iff (!i_arst_n)
        raster.x < video_pkg::coord_t'(`H_TOTAL));

    a_y_in_frame: assert property (@(posedge clk) disable iff (!i_arst_n)
        raster.y < video_pkg::coord_t'(`V_TOTAL));

endmodule

//--- hdl/bar_pattern.sv
`include "video_macros.svh"

module bar_pattern
(
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic [2:0]  i_key,
    video_if.snk        raster,
    video_if.src        paint
);

    logic [2:0]         bar_idx;
    video_pkg::pixel_t  bar_pix;

    //------------------
    // colour of the current pixel
    //------------------

    // bars 8 and 9 fall into blanking and are masked below
    assign bar_idx = 3'(raster.x / `BAR_WIDTH);

    always_comb
    begin
        // each bar index bit lights one channel, each key flips one
        bar_pix.red   = {8{bar_idx[2] ^ i_key[2]}};
        bar_pix.green = {8{bar_idx[1] ^ i_key[1]}};
        bar_pix.blue  = {8{bar_idx[0] ^ i_key[0]}};

        // black outside the visible area
        if (!raster.de)
            bar_pix = '0;
    end

    //------------------
    // output stage
    //------------------

    // control levels
    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            paint.hsync <= 1'b0;
            paint.vsync <= 1'b0;
            paint.de    <= 1'b0;
        end
        else
        begin
            paint.hsync <= raster.hsync;
            paint.vsync <= raster.vsync;
            paint.de    <= raster.de;
        end
    end

    // position and colour follow the control levels by the same one clock
    always_ff @(posedge clk)
    begin
        paint.x     <= raster.x;
        paint.y     <= raster.y;
        paint.pixel <= bar_pix;
    end

endmodule

//--- hdl/tmds_encoder.sv
module tmds_encoder
# (
    // only the blue channel carries hsync and vsync
    parameter bit sync_channel = 1'b0
)
(
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  video_pkg::colour_t       i_data,
    input  logic                     i_de,
    input  logic                     i_c0,
    input  logic                     i_c1,
    output video_pkg::tmds_word_t    o_tmds
);

    // control symbols indexed by {c1, c0}
    localparam video_pkg::tmds_word_t ctrl_00 = 10'b1101010100;
    localparam video_pkg::tmds_word_t ctrl_01 = 10'b0010101011;
    localparam video_pkg::tmds_word_t ctrl_10 = 10'b0101010100;
    localparam video_pkg::tmds_word_t ctrl_11 = 10'b1010101011;

    function automatic logic [3:0] ones8 (input video_pkg::colour_t v);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++)
            n = n + 4'(v[i]);
        return n;
    endfunction

    //------------------
    // stage one
    //------------------

    logic [3:0]  data_ones;
    logic        use_xnor;
    logic [8:0]  qm_next;

    logic [8:0]  qm_q;
    logic        de_q;
    logic        c0_q;
    logic        c1_q;

    // transition minimising, XNOR chain when the byte is mostly ones
    always_comb
    begin
        data_ones  = ones8(i_data);
        use_xnor   = (data_ones > 4'd4) || ((data_ones == 4'd4) && !i_data[0]);
        qm_next[0] = i_data[0];

        for (int i = 1; i < 8; i++)
            qm_next[i] = use_xnor ? ~(qm_next[i - 1] ^ i_data[i])
                                  :  (qm_next[i - 1] ^ i_data[i]);

        // bit 8 is set for the XOR chain
        qm_next[8] = !use_xnor;
    end

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            de_q <= 1'b0;
            c0_q <= 1'b0;
            c1_q <= 1'b0;
        end
        else
        begin
            de_q <= i_de;
            // a channel without sync only ever sends the 00 control code
            c0_q <= i_c0 & sync_channel;
            c1_q <= i_c1 & sync_channel;
        end
    end

    always_ff @(posedge clk)
        qm_q <= qm_next;

    //------------------
    // stage two
    //------------------

    logic [3:0]              qm_ones;
    video_pkg::disparity_t   bal;
    video_pkg::disparity_t   disp;
    video_pkg::disparity_t   disp_next;
    video_pkg::tmds_word_t   word_next;

    always_comb
    begin
        qm_ones = ones8(qm_q[7:0]);
        // ones minus zeros of the chained byte, -8..8
        bal     = video_pkg::disparity_t'(qm_ones)
                - video_pkg::disparity_t'(4'd8 - qm_ones);

        if (!de_q)
        begin
            // blanking restarts the DC count
            disp_next = '0;

            case ({c1_q, c0_q})
                2'b00:   word_next = ctrl_00;
                2'b01:   word_next = ctrl_01;
                2'b10:   word_next = ctrl_10;
                default: word_next = ctrl_11;
            endcase
        end
        else if ((disp == 0) || (bal == 0))
        begin
            // no bias either way, invert only for the XNOR chain
            word_next = {~qm_q[8], qm_q[8], qm_q[8] ? qm_q[7:0] : ~qm_q[7:0]};
            disp_next = qm_q[8] ? disp + bal : disp - bal;
        end
        else if (((disp > 0) && (bal > 0)) || ((disp < 0) && (bal < 0)))
        begin
            // this byte would push the count further away, so send it inverted
            word_next = {1'b1, qm_q[8], ~qm_q[7:0]};
            disp_next = disp + (qm_q[8] ? 5'sd2 : 5'sd0) - bal;
        end
        else
        begin
            word_next = {1'b0, qm_q[8], qm_q[7:0]};
            disp_next = disp - (qm_q[8] ? 5'sd0 : 5'sd2) + bal;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_tmds <= ctrl_00;
            disp   <= '0;
        end
        else
        begin
            o_tmds <= word_next;
            disp   <= disp_next;
        end
    end

    //------------------
    // checks
    //------------------

    a_disp_bound: assert property (@(posedge clk) disable iff (!i_arst_n)
        (disp >= -10) && (disp <= 10));

endmodule

//--- hdl/dvi_video_top.sv
module dvi_video_top
(
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic [2:0]               i_key,
    output video_pkg::tmds_word_t    o_tmds_red,
    output video_pkg::tmds_word_t    o_tmds_green,
    output video_pkg::tmds_word_t    o_tmds_blue
);

    //------------------
    // raster and picture
    //------------------

    video_if raster_if ();
    video_if paint_if  ();

    vga_timing vga_timing_inst
    (
        .clk       ( clk              ),
        .i_arst_n  ( i_arst_n         ),
        .raster    ( raster_if.src    )
    );

    bar_pattern bar_pattern_inst
    (
        .clk       ( clk              ),
        .i_arst_n  ( i_arst_n         ),
        .i_key     ( i_key            ),
        .raster    ( raster_if.snk    ),
        .paint     ( paint_if.src     )
    );

    //------------------
    // one encoder per channel
    //------------------

    tmds_encoder # (.sync_channel ( 1'b0 )) enc_red
    (
        .clk       ( clk                    ),
        .i_arst_n  ( i_arst_n               ),
        .i_data    ( paint_if.pixel.red     ),
        .i_de      ( paint_if.de            ),
        .i_c0      ( 1'b0                   ),
        .i_c1      ( 1'b0                   ),
        .o_tmds    ( o_tmds_red             )
    );

    tmds_encoder # (.sync_channel ( 1'b0 )) enc_green
    (
        .clk       ( clk                    ),
        .i_arst_n  ( i_arst_n               ),
        .i_data    ( paint_if.pixel.green   ),
        .i_de      ( paint_if.de            ),
        .i_c0      ( 1'b0                   ),
        .i_c1      ( 1'b0                   ),
        .o_tmds    ( o_tmds_green           )
    );

    // DVI puts hsync on c0 and vsync on c1 of channel 0
    tmds_encoder # (.sync_channel ( 1'b1 )) enc_blue
    (
        .clk       ( clk                    ),
        .i_arst_n  ( i_arst_n               ),
        .i_data    ( paint_if.pixel.blue    ),
        .i_de      ( paint_if.de            ),
        .i_c0      ( paint_if.hsync         ),
        .i_c1      ( paint_if.vsync         ),
        .o_tmds    ( o_tmds_blue            )
    );

endmodule

//--- tests/tb_clock.sv
module tb_clock
(
    output logic o_clk,
    output logic o_arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns pixel clock
    initial
    begin
        o_clk = 1'b0;
        forever
            #50 o_clk = ~o_clk;
    end

    // reset held over the first two rising edges, released just after the second
    initial
    begin
        o_arst_n = 1'b0;
        repeat (2)
            @(posedge o_clk);
        #10 o_arst_n = 1'b1;
    end

endmodule

//--- tests/tb_dvi_video_top.sv
`include "video_macros.svh"

module tb_dvi_video_top;

    timeunit 1ns;
    timeprecision 100ps;

    // three and a third frames
    localparam int max_cycles = 10 * `H_TOTAL * `V_TOTAL / 3;

    logic                    clk;
    logic                    arst_n;
    logic [2:0]              key;
    video_pkg::tmds_word_t   tmds_red;
    video_pkg::tmds_word_t   tmds_green;
    video_pkg::tmds_word_t   tmds_blue;
    int                      cycles = 0;

    tb_clock tb_clock_inst
    (
        .o_clk     ( clk    ),
        .o_arst_n  ( arst_n )
    );

    dvi_video_top dvi_video_top_inst
    (
        .clk           ( clk        ),
        .i_arst_n      ( arst_n     ),
        .i_key         ( key        ),
        .o_tmds_red    ( tmds_red   ),
        .o_tmds_green  ( tmds_green ),
        .o_tmds_blue   ( tmds_blue  )
    );

    //------------------
    // failure and compare tasks
    //------------------

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input video_pkg::tmds_word_t got,
                              input video_pkg::tmds_word_t exp);
        if (got !== exp)
            fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_colour(input string name, input video_pkg::colour_t got,
                                input video_pkg::colour_t exp);
        if (got !== exp)
            fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_coord(input string name, input video_pkg::coord_t got,
                               input video_pkg::coord_t exp);
        if (got !== exp)
            fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    //------------------
    // model decoder
    //------------------

    function automatic video_pkg::tmds_word_t ctrl_code(input logic [1:0] c);
        case (c)
            2'b00:   return 10'b1101010100;
            2'b01:   return 10'b0010101011;
            2'b10:   return 10'b0101010100;
            default: return 10'b1010101011;
        endcase
    endfunction

    function automatic logic is_ctrl(input video_pkg::tmds_word_t w);
        logic hit;
        hit = 1'b0;
        for (int c = 0; c < 4; c++)
            if (w == ctrl_code(2'(c)))
                hit = 1'b1;
        return hit;
    endfunction

    // {c1, c0} of a control word, zero for data words
    function automatic logic [1:0] ctrl_bits(input video_pkg::tmds_word_t w);
        logic [1:0] bits;
        bits = 2'b00;
        for (int c = 0; c < 4; c++)
            if (w == ctrl_code(2'(c)))
                bits = 2'(c);
        return bits;
    endfunction

    // undo the inversion, then the XOR or XNOR chain
    function automatic video_pkg::colour_t decode_byte(input video_pkg::tmds_word_t w);
        logic [7:0]           q;
        video_pkg::colour_t   d;
        q = w[9] ? ~w[7:0] : w[7:0];
        d[0] = q[0];
        for (int i = 1; i < 8; i++)
            d[i] = w[8] ? (q[i] ^ q[i - 1]) : ~(q[i] ^ q[i - 1]);
        return d;
    endfunction

    // bar index bit b lights the channel, the key bit flips it
    function automatic video_pkg::colour_t bar_level(input int k, input int b, input logic flip);
        int idx;
        idx = k / `BAR_WIDTH;
        return (idx[b] ^ flip) ? 8'hFF : 8'h00;
    endfunction

    //------------------
    // stream alignment
    //------------------

    task automatic wait_active_start();
        do
            @(negedge clk);
        while (is_ctrl(tmds_blue));
    endtask

    task automatic wait_vsync();
        logic [1:0] c;
        c = 2'b00;
        while (!c[1])
        begin
            @(negedge clk);
            c = ctrl_bits(tmds_blue);
        end
    endtask

    // the 480 active lines of the next frame against the bars for the given keys
    task automatic scan_bars(input logic [2:0] keys);
        wait_active_start();
        for (int line = 0; line < `V_ACTIVE; line++)
        begin
            while (is_ctrl(tmds_blue))
                @(negedge clk);
            for (int k = 0; k < `H_ACTIVE; k++)
            begin
                if (is_ctrl(tmds_blue))
                    fail_run($sformatf("active line %0d ended after %0d data words", line, k));
                check_colour("o_tmds_red byte", decode_byte(tmds_red), bar_level(k, 2, keys[2]));
                check_colour("o_tmds_green byte", decode_byte(tmds_green),
                             bar_level(k, 1, keys[1]));
                check_colour("o_tmds_blue byte", decode_byte(tmds_blue),
                             bar_level(k, 0, keys[0]));
                @(negedge clk);
            end
        end
    endtask

    // checks one data word against the DVI rule and moves the running count on
    task automatic check_balance(input string name, input video_pkg::tmds_word_t got,
                                 inout int disp);
        logic [8:0] qm;
        int         n1;
        int         n0;
        logic       inv;
        qm = {got[8], got[9] ? ~got[7:0] : got[7:0]};
        n1 = $countones(qm[7:0]);
        n0 = 8 - n1;
        if ((disp == 0) || (n1 == n0))
            inv = ~qm[8];
        else if (((disp > 0) && (n1 > n0)) || ((disp < 0) && (n0 > n1)))
            inv = 1'b1;
        else
            inv = 1'b0;
        check_word(name, got, {inv, qm[8], inv ? ~qm[7:0] : qm[7:0]});
        if ((disp == 0) || (n1 == n0))
            disp = qm[8] ? disp + n1 - n0 : disp + n0 - n1;
        else if (inv)
            disp = disp + (qm[8] ? 2 : 0) + n0 - n1;
        else
            disp = disp - (qm[8] ? 0 : 2) + n1 - n0;
        if ((disp > 10) || (disp < -10))
            fail_run($sformatf("%s running disparity reached %0d", name, disp));
    endtask

    //------------------
    // tests
    //------------------

    task automatic test_reset_state();
        do
        begin
            @(negedge clk);
            check_word("o_tmds_red", tmds_red, ctrl_code(2'b00));
            check_word("o_tmds_green", tmds_green, ctrl_code(2'b00));
            check_word("o_tmds_blue", tmds_blue, ctrl_code(2'b00));
        end
        while (!arst_n);
        // first edge after the release still shows the idle code
        @(negedge clk);
        check_word("o_tmds_red", tmds_red, ctrl_code(2'b00));
        check_word("o_tmds_green", tmds_green, ctrl_code(2'b00));
        check_word("o_tmds_blue", tmds_blue, ctrl_code(2'b00));
    endtask

    task automatic test_sync_framing();
        int         hs_run;
        int         de_run;
        int         de_lines;
        int         vs_words;
        int         hs_count;
        int         last_hs;
        logic [1:0] c;
        logic       prev_hs;
        hs_run = 0;
        de_run = 0;
        de_lines = 0;
        vs_words = 0;
        hs_count = 0;
        last_hs = -1;
        prev_hs = 1'b0;
        wait_active_start();
        for (int n = 0; n < `H_TOTAL * `V_TOTAL; n++)
        begin
            c = ctrl_bits(tmds_blue);
            if (is_ctrl(tmds_blue))
            begin
                check_word("o_tmds_red", tmds_red, ctrl_code(2'b00));
                check_word("o_tmds_green", tmds_green, ctrl_code(2'b00));
                if (de_run > 0)
                begin
                    check_coord("o_tmds_blue active words", video_pkg::coord_t'(de_run),
                                video_pkg::coord_t'(`H_ACTIVE));
                    de_lines++;
                    de_run = 0;
                end
                if (c[1])
                    vs_words++;
            end
            else
                de_run++;
            if (c[0] && !prev_hs)
            begin
                if (last_hs >= 0)
                    check_coord("o_tmds_blue hsync period", video_pkg::coord_t'(n - last_hs),
                                video_pkg::coord_t'(`H_TOTAL));
                last_hs = n;
                hs_count++;
            end
            else if (!c[0] && prev_hs)
            begin
                check_coord("o_tmds_blue hsync width", video_pkg::coord_t'(hs_run),
                            video_pkg::coord_t'(`H_SYNC));
                hs_run = 0;
            end
            if (c[0])
                hs_run++;
            prev_hs = c[0];
            @(negedge clk);
        end
        check_coord("o_tmds_blue hsync count", video_pkg::coord_t'(hs_count),
                    video_pkg::coord_t'(`V_TOTAL));
        check_coord("o_tmds_blue active lines", video_pkg::coord_t'(de_lines),
                    video_pkg::coord_t'(`V_ACTIVE));
        if (vs_words != `V_SYNC * `H_TOTAL)
            fail_run($sformatf("vsync lasted %0d words in one frame instead of %0d",
                               vs_words, `V_SYNC * `H_TOTAL));
    endtask

    task automatic test_colour_bars();
        scan_bars(3'b000);
    endtask

    task automatic test_key_inversion();
        for (int f = 0; f < 2; f++)
        begin
            wait_vsync();
            @(posedge clk);
            #10;
            key = 3'($urandom);
            $display("key inversion frame %0d with keys 0x%h", f, key);
            scan_bars(key);
        end
    endtask

    task automatic test_dc_balance();
        int disp_r;
        int disp_g;
        int disp_b;
        wait_active_start();
        for (int line = 0; line < `V_ACTIVE; line++)
        begin
            while (is_ctrl(tmds_blue))
                @(negedge clk);
            // blanking clears the count at the transmitter
            disp_r = 0;
            disp_g = 0;
            disp_b = 0;
            for (int k = 0; k < `H_ACTIVE; k++)
            begin
                check_balance("o_tmds_red", tmds_red, disp_r);
                check_balance("o_tmds_green", tmds_green, disp_g);
                check_balance("o_tmds_blue", tmds_blue, disp_b);
                @(negedge clk);
            end
        end
    endtask

    //------------------
    // run control
    //------------------

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= max_cycles)
            fail_run($sformatf("timeout, tests still running after %0d cycles", cycles));
    end

    initial
    begin
        key = 3'b000;
        void'($urandom(84390));
        test_reset_state();
        // frame 0 feeds framing, bars and balance, then two keyed frames follow
        fork
            test_sync_framing();
            test_dc_balance();
            begin
                test_colour_bars();
                test_key_inversion();
            end
        join
        $display("Verification passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/video_pkg.sv
hdl/video_if.sv
hdl/vga_timing.sv
hdl/bar_pattern.sv
hdl/tmds_encoder.sv
hdl/dvi_video_top.sv
tests/tb_clock.sv
tests/tb_dvi_video_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
        -f flist.f --top-module tb_dvi_video_top -o tb_sim \
    && ./obj_dir/tb_sim | grep -q "Verification passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
